/* source/slc3Pkg.sv */
package slc3Pkg;

	// One machine word on the bus, in a register or in memory
	typedef logic [15:0] dataWord;
	// Register file index
	typedef logic [2:0] regIndex;

	// IR[15:12] encodings of the supported instructions
	typedef enum logic [3:0] {
		opBr    = 4'b0000,
		opAdd   = 4'b0001,
		opLd    = 4'b0010,
		opSt    = 4'b0011,
		opAnd   = 4'b0101,
		opNot   = 4'b1001,
		opJmp   = 4'b1100,
		opPause = 4'b1101
	} opcodeT;

	// Control sequencer states
	typedef enum logic [4:0] {
		sHalted,
		sFetchAddr,
		sFetchRead,
		sFetchIr,
		sDecode,
		sAluExec,
		sBranch,
		sJmp,
		sLdAddr,
		sLdRead,
		sLdLoad,
		sStAddr,
		sStData,
		sStWrite,
		sPause,
		sPauseRelease
	} ctrlState;

	// PC input select
	localparam logic [1:0] pcInc = 2'd0;
	localparam logic [1:0] pcBus = 2'd1;
	localparam logic [1:0] pcAdder = 2'd2;

	// Offset select of the address adder
	localparam logic [1:0] addr2Zero = 2'd0;
	localparam logic [1:0] addr2Off6 = 2'd1;
	localparam logic [1:0] addr2Off9 = 2'd2;

	// ALU function
	localparam logic [1:0] aluAdd = 2'd0;
	localparam logic [1:0] aluAnd = 2'd1;
	localparam logic [1:0] aluNot = 2'd2;
	localparam logic [1:0] aluPassA = 2'd3;

	// Everything the sequencer tells the datapath and register file
	typedef struct packed {
		logic ldMar;
		logic ldMdr;
		logic ldIr;
		logic ldPc;
		logic ldReg;
		logic ldCc;
		logic ldBen;
		logic ldLed;
		logic gatePc;
		logic gateMdr;
		logic gateAlu;
		logic gateMarMux;
		logic [1:0] pcMux;
		// 0 selects PC, 1 selects SR1
		logic addr1Mux;
		logic [1:0] addr2Mux;
		// 1 selects imm5
		logic sr2Mux;
		logic [1:0] aluK;
		// MDR takes memory data instead of the bus
		logic mioEn;
	} ctrlSignals;

	// CPU side memory access
	typedef struct packed {
		dataWord addr;
		dataWord wrData;
		logic read;
		logic write;
	} memReq;

endpackage

/* source/hexDriver.sv */
module hexDriver (
	input logic [3:0] nibble,
	output logic [6:0] segments
);

	// Active low, bit order gfedcba
	always_comb begin
		case (nibble)
			4'h0: segments = 7'b1000000;
			4'h1: segments = 7'b1111001;
			4'h2: segments = 7'b0100100;
			4'h3: segments = 7'b0110000;
			4'h4: segments = 7'b0011001;
			4'h5: segments = 7'b0010010;
			4'h6: segments = 7'b0000010;
			4'h7: segments = 7'b1111000;
			4'h8: segments = 7'b0000000;
			4'h9: segments = 7'b0010000;
			4'hA: segments = 7'b0001000;
			// Lower case b and d so they differ from 8 and 0
			4'hB: segments = 7'b0000011;
			4'hC: segments = 7'b1000110;
			4'hD: segments = 7'b0100001;
			4'hE: segments = 7'b0000110;
			4'hF: segments = 7'b0001110;
			default: segments = 7'b1111111;
		endcase
	end

endmodule

/* source/regFile.sv */
module regFile import slc3Pkg::*; (
	input logic Clk,
	input logic rst,
	input ctrlSignals ctrl,
	input dataWord ir,
	input dataWord bus,
	output dataWord sr1Out,
	output dataWord sr2Out
);

	dataWord regs [8];
	regIndex dr;
	regIndex sr1Sel;
	regIndex sr2Sel;
	opcodeT opcode;

	assign opcode = opcodeT'(ir[15:12]);

	// Destination is always IR[11:9]
	assign dr = ir[11:9];
	// ST reads its source from the DR field
	assign sr1Sel = (opcode == opSt) ? ir[11:9] : ir[8:6];
	assign sr2Sel = ir[2:0];

	// Write port
	always_ff @(posedge Clk) begin
		if (rst) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (ctrl.ldReg) begin
			regs[dr] <= bus;
		end
	end

	// Two asynchronous read ports
	assign sr1Out = regs[sr1Sel];
	assign sr2Out = regs[sr2Sel];

endmodule

/* source/datapath.sv */
module datapath import slc3Pkg::*; #(
	parameter dataWord resetPc = 16'h0000
) (
	input logic Clk,
	input logic rst,
	input ctrlSignals ctrl,
	input dataWord sr1Out,
	input dataWord sr2Out,
	input dataWord rdData,
	output dataWord bus,
	output dataWord ir,
	output dataWord pc,
	output dataWord mar,
	output dataWord mdr,
	output logic ben,
	output logic [11:0] led
);

	dataWord imm5;
	dataWord off6;
	dataWord off9;
	dataWord aluB;
	dataWord aluOut;
	dataWord addrBase;
	dataWord addrOff;
	dataWord marMux;
	dataWord mdrSrc;
	dataWord pcNext;
	logic flagN;
	logic flagZ;
	logic flagP;
	logic busN;
	logic busZ;

	// Sign extended IR fields
	assign imm5 = {{11{ir[4]}}, ir[4:0]};
	assign off6 = {{10{ir[5]}}, ir[5:0]};
	assign off9 = {{7{ir[8]}}, ir[8:0]};

	// ALU
	assign aluB = ctrl.sr2Mux ? imm5 : sr2Out;
	always_comb begin
		case (ctrl.aluK)
			aluAdd: aluOut = sr1Out + aluB;
			aluAnd: aluOut = sr1Out & aluB;
			aluNot: aluOut = ~sr1Out;
			default: aluOut = sr1Out;
		endcase
	end

	// Address adder; PC already points past the current instruction
	assign addrBase = ctrl.addr1Mux ? sr1Out : pc;
	always_comb begin
		case (ctrl.addr2Mux)
			addr2Off6: addrOff = off6;
			addr2Off9: addrOff = off9;
			default: addrOff = '0;
		endcase
	end
	assign marMux = addrBase + addrOff;

	// With mioEn the MDR gate forwards fresh memory data
	// so IR or a register can take it in the same cycle as MDR
	assign mdrSrc = ctrl.mioEn ? rdData : mdr;

	// Single source bus, zero when nothing is gated
	always_comb begin
		if (ctrl.gatePc) begin
			bus = pc;
		end else if (ctrl.gateMdr) begin
			bus = mdrSrc;
		end else if (ctrl.gateAlu) begin
			bus = aluOut;
		end else if (ctrl.gateMarMux) begin
			bus = marMux;
		end else begin
			bus = '0;
		end
	end

	always_comb begin
		case (ctrl.pcMux)
			pcBus: pcNext = bus;
			pcAdder: pcNext = marMux;
			default: pcNext = pc + 16'd1;
		endcase
	end

	// Flags of the value now on the bus
	assign busN = bus[15];
	assign busZ = (bus == '0);

	// Control registers
	always_ff @(posedge Clk) begin
		if (rst) begin
			pc <= resetPc;
			ir <= '0;
			led <= '0;
			flagN <= 1'b0;
			flagZ <= 1'b0;
			flagP <= 1'b0;
			ben <= 1'b0;
		end else begin
			if (ctrl.ldPc) begin
				pc <= pcNext;
			end
			if (ctrl.ldIr) begin
				ir <= bus;
			end
			if (ctrl.ldLed) begin
				led <= ir[11:0];
			end
			if (ctrl.ldCc) begin
				flagN <= busN;
				flagZ <= busZ;
				flagP <= ~busN & ~busZ;
			end
			// Branch condition from IR[11:9] against current flags
			if (ctrl.ldBen) begin
				ben <= (ir[11] & flagN) | (ir[10] & flagZ) | (ir[9] & flagP);
			end
		end
	end

	// Address and data registers
	always_ff @(posedge Clk) begin
		if (ctrl.ldMar) begin
			mar <= bus;
		end
		if (ctrl.ldMdr) begin
			mdr <= ctrl.mioEn ? rdData : bus;
		end
	end

endmodule

/* source/controlUnit.sv */
module controlUnit import slc3Pkg::*; (
	input logic Clk,
	input logic rst,
	input logic run,
	// Continue button, level
	input logic cont,
	input dataWord ir,
	input logic ben,
	output ctrlSignals ctrl,
	output logic memRead,
	output logic memWrite
);

	ctrlState state;
	ctrlState nextState;
	opcodeT opcode;

	assign opcode = opcodeT'(ir[15:12]);

	always_ff @(posedge Clk) begin
		if (rst) begin
			state <= sHalted;
		end else begin
			state <= nextState;
		end
	end

	// Next state
	always_comb begin
		nextState = state;
		case (state)
			sHalted: begin
				if (run) begin
					nextState = sFetchAddr;
				end
			end
			sFetchAddr: nextState = sFetchRead;
			sFetchRead: nextState = sFetchIr;
			sFetchIr: nextState = sDecode;
			sDecode: begin
				case (opcode)
					opAdd, opAnd, opNot: nextState = sAluExec;
					opBr: nextState = sBranch;
					opJmp: nextState = sJmp;
					opLd: nextState = sLdAddr;
					opSt: nextState = sStAddr;
					opPause: nextState = sPause;
					// Unsupported opcode, just fetch the next one
					default: nextState = sFetchAddr;
				endcase
			end
			sLdAddr: nextState = sLdRead;
			sLdRead: nextState = sLdLoad;
			sStAddr: nextState = sStData;
			sStData: nextState = sStWrite;
			// Hold until continue rises, then until it falls
			sPause: begin
				if (cont) begin
					nextState = sPauseRelease;
				end
			end
			sPauseRelease: begin
				if (!cont) begin
					nextState = sFetchAddr;
				end
			end
			sAluExec, sBranch, sJmp, sLdLoad, sStWrite: nextState = sFetchAddr;
			default: nextState = sHalted;
		endcase
	end

	// Per state controls
	always_comb begin
		ctrl = '0;
		memRead = 1'b0;
		memWrite = 1'b0;
		case (state)
			// MAR <- PC, PC <- PC + 1
			sFetchAddr: begin
				ctrl.gatePc = 1'b1;
				ctrl.ldMar = 1'b1;
				ctrl.ldPc = 1'b1;
				ctrl.pcMux = pcInc;
			end
			sFetchRead: memRead = 1'b1;
			// MDR and IR both take the returned word
			sFetchIr: begin
				ctrl.mioEn = 1'b1;
				ctrl.ldMdr = 1'b1;
				ctrl.gateMdr = 1'b1;
				ctrl.ldIr = 1'b1;
			end
			sDecode: ctrl.ldBen = 1'b1;
			sAluExec: begin
				ctrl.gateAlu = 1'b1;
				ctrl.ldReg = 1'b1;
				ctrl.ldCc = 1'b1;
				// IR[5] picks imm5 over SR2
				ctrl.sr2Mux = ir[5];
				case (opcode)
					opAnd: ctrl.aluK = aluAnd;
					opNot: ctrl.aluK = aluNot;
					default: ctrl.aluK = aluAdd;
				endcase
			end
			// PC <- PC + off9 when the branch is taken
			sBranch: begin
				ctrl.ldPc = ben;
				ctrl.pcMux = pcAdder;
				ctrl.addr2Mux = addr2Off9;
			end
			// PC <- BaseR
			sJmp: begin
				ctrl.ldPc = 1'b1;
				ctrl.pcMux = pcAdder;
				ctrl.addr1Mux = 1'b1;
				ctrl.addr2Mux = addr2Zero;
			end
			sLdAddr, sStAddr: begin
				ctrl.gateMarMux = 1'b1;
				ctrl.ldMar = 1'b1;
				ctrl.addr2Mux = addr2Off9;
			end
			sLdRead: memRead = 1'b1;
			sLdLoad: begin
				ctrl.mioEn = 1'b1;
				ctrl.ldMdr = 1'b1;
				ctrl.gateMdr = 1'b1;
				ctrl.ldReg = 1'b1;
				ctrl.ldCc = 1'b1;
			end
			// MDR <- SR through the ALU
			sStData: begin
				ctrl.aluK = aluPassA;
				ctrl.gateAlu = 1'b1;
				ctrl.ldMdr = 1'b1;
			end
			sStWrite: memWrite = 1'b1;
			sPause: ctrl.ldLed = 1'b1;
			default: ctrl = '0;
		endcase
	end

endmodule

/* source/memIo.sv */
module memIo import slc3Pkg::*; #(
	parameter dataWord ioAddress = 16'hFFFF
) (
	input logic Clk,
	input logic rst,
	input memReq req,
	input dataWord switches,
	input dataWord memRdData,
	output dataWord rdData,
	output dataWord memAddr,
	output dataWord memWrData,
	output logic memRead,
	output logic memWrite,
	output dataWord display
);

	logic isIo;
	logic ioPending;
	dataWord switchLatch;

	assign isIo = (req.addr == ioAddress);

	// External port, strobes masked for the I/O address
	assign memAddr = req.addr;
	assign memWrData = req.wrData;
	assign memRead = req.read & ~isIo;
	assign memWrite = req.write & ~isIo;

	// Remember which side answers the read
	always_ff @(posedge Clk) begin
		if (rst) begin
			ioPending <= 1'b0;
			display <= '0;
		end else begin
			ioPending <= req.read & isIo;
			if (req.write && isIo) begin
				display <= req.wrData;
			end
		end
	end

	// Switches sampled at the strobe, same latency as memory
	always_ff @(posedge Clk) begin
		if (req.read && isIo) begin
			switchLatch <= switches;
		end
	end

	assign rdData = ioPending ? switchLatch : memRdData;

endmodule

/* source/slc3.sv */
module slc3 import slc3Pkg::*; #(
	parameter dataWord resetPc = 16'h0000,
	parameter dataWord ioAddress = 16'hFFFF
) (
	input logic Clk,
	input logic rst,
	input logic run,
	// Continue button, level
	input logic cont,
	input dataWord switches,
	input dataWord memRdData,
	output dataWord memAddr,
	output dataWord memWrData,
	output logic memRead,
	output logic memWrite,
	output logic [11:0] led,
	output dataWord pc,
	output dataWord ir,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex2,
	output logic [6:0] hex3,
	output logic [6:0] hex4,
	output logic [6:0] hex5,
	output logic [6:0] hex6,
	output logic [6:0] hex7
);

	ctrlSignals ctrl;
	dataWord bus;
	dataWord sr1Out;
	dataWord sr2Out;
	dataWord rdData;
	dataWord mar;
	dataWord mdr;
	dataWord display;
	logic ben;
	logic cpuRead;
	logic cpuWrite;
	memReq req;

	// CPU request, address from MAR and data from MDR
	assign req = '{addr: mar, wrData: mdr, read: cpuRead, write: cpuWrite};

	datapath #(.resetPc(resetPc)) u_datapath (
		.Clk, .rst, .ctrl, .sr1Out, .sr2Out, .rdData,
		.bus, .ir, .pc, .mar, .mdr, .ben, .led
	);

	regFile u_regFile (.Clk, .rst, .ctrl, .ir, .bus, .sr1Out, .sr2Out);

	controlUnit u_controlUnit (
		.Clk, .rst, .run, .cont, .ir, .ben, .ctrl,
		.memRead(cpuRead), .memWrite(cpuWrite)
	);

	memIo #(.ioAddress(ioAddress)) u_memIo (
		.Clk, .rst, .req, .switches, .memRdData, .rdData,
		.memAddr, .memWrData, .memRead, .memWrite, .display
	);

	// Display register on the low digits
	hexDriver u_hex0 (.nibble(display[3:0]), .segments(hex0));
	hexDriver u_hex1 (.nibble(display[7:4]), .segments(hex1));
	hexDriver u_hex2 (.nibble(display[11:8]), .segments(hex2));
	hexDriver u_hex3 (.nibble(display[15:12]), .segments(hex3));
	// PC on the high digits
	hexDriver u_hex4 (.nibble(pc[3:0]), .segments(hex4));
	hexDriver u_hex5 (.nibble(pc[7:4]), .segments(hex5));
	hexDriver u_hex6 (.nibble(pc[11:8]), .segments(hex6));
	hexDriver u_hex7 (.nibble(pc[15:12]), .segments(hex7));

endmodule

/* bench/controlUnit_properties.sv */
module controlUnitProperties import slc3Pkg::*; (
	input logic Clk,
	input logic rst,
	input ctrlState state,
	input logic memRead,
	input logic memWrite
);

	// One strobe at a time
	strobeExclusive: assert property (@(posedge Clk) disable iff (rst)
		!(memRead && memWrite))
		else $error("memRead and memWrite high in the same cycle");

	// A halted machine stays off the memory port
	haltedQuiet: assert property (@(posedge Clk) disable iff (rst)
		(state == sHalted) |-> !(memRead || memWrite))
		else $error("memory strobe issued in sHalted");

	// Only the enumerated states are reachable
	legalState: assert property (@(posedge Clk) disable iff (rst)
		!$isunknown(state) && (state <= sPauseRelease))
		else $error("control state outside the legal set");

	// Stores write on their last execute cycle only
	writeInStWrite: assert property (@(posedge Clk) disable iff (rst)
		memWrite |-> (state == sStWrite))
		else $error("memWrite outside sStWrite");

endmodule

bind controlUnit controlUnitProperties u_properties (
	.Clk, .rst, .state, .memRead, .memWrite
);

/* bench/slc3Tb.sv */
module slc3Tb import slc3Pkg::*; ();

	localparam int numTests = 5;
	// Instructions in the longest test program
	localparam int maxProgram = 13;
	localparam int cycleLimit = 200 * maxProgram * numTests;

	// LC-3 opcode fields
	localparam logic [3:0] opcAdd = 4'b0001;
	localparam logic [3:0] opcAnd = 4'b0101;
	localparam logic [3:0] opcLd = 4'b0010;
	localparam logic [3:0] opcSt = 4'b0011;

	// Active low gfedcba digit patterns indexed by nibble
	localparam logic [15:0][6:0] segTable = {
		7'h0E, 7'h06, 7'h21, 7'h46, 7'h03, 7'h08, 7'h10, 7'h00,
		7'h78, 7'h02, 7'h12, 7'h19, 7'h30, 7'h24, 7'h79, 7'h40
	};

	logic Clk;
	logic rst;
	logic run;
	logic cont;
	dataWord switches;
	dataWord memRdData;
	dataWord memAddr;
	dataWord memWrData;
	logic memRead;
	logic memWrite;
	logic [11:0] led;
	dataWord pc;
	dataWord ir;
	logic [7:0][6:0] hex;

	dataWord mem [65536];
	// Every external write in order
	dataWord wrAddrQ [$];
	dataWord wrDataQ [$];
	int readCount;
	int ioStrobes;
	int errors;
	int errAtStart;
	int testsRun;
	int testsFailed;
	int cycles;

	slc3 u_dut (
		.Clk, .rst, .run, .cont, .switches, .memRdData, .memAddr, .memWrData,
		.memRead, .memWrite, .led, .pc, .ir,
		.hex0(hex[0]), .hex1(hex[1]), .hex2(hex[2]), .hex3(hex[3]),
		.hex4(hex[4]), .hex5(hex[5]), .hex6(hex[6]), .hex7(hex[7])
	);

	initial begin
		Clk = 1'b0;
		forever #10 Clk = ~Clk;
	end

	// Synchronous SRAM with read data one cycle after the strobe
	always @(posedge Clk) begin
		if (memRead) begin
			memRdData <= mem[memAddr];
			readCount++;
		end
		if (memWrite) begin
			mem[memAddr] <= memWrData;
			wrAddrQ.push_back(memAddr);
			wrDataQ.push_back(memWrData);
		end
		if ((memRead || memWrite) && memAddr == 16'hFFFF)
			ioStrobes++;
	end

	// PC relative 9-bit offset from the instruction at here
	function automatic logic [8:0] offset9(dataWord here, dataWord target);
		dataWord diff;
		diff = target - here - 16'd1;
		return diff[8:0];
	endfunction

	function automatic dataWord aluReg(logic [3:0] opc, regIndex dr, regIndex sa, regIndex sb);
		return {opc, dr, sa, 3'b000, sb};
	endfunction

	function automatic dataWord aluImm(logic [3:0] opc, regIndex dr, regIndex sa, logic [4:0] imm);
		return {opc, dr, sa, 1'b1, imm};
	endfunction

	function automatic dataWord memOp(logic [3:0] opc, regIndex r, dataWord here, dataWord target);
		return {opc, r, offset9(here, target)};
	endfunction

	function automatic dataWord branch(logic [2:0] nzp, dataWord here, dataWord target);
		return {4'b0000, nzp, offset9(here, target)};
	endfunction

	task automatic checkWord(string name, dataWord expected, dataWord actual);
		if (actual !== expected) begin
			errors++;
			$display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic checkSeg(string name, logic [6:0] expected, logic [6:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("error at %0t: %s expected %b, got %b", $time, name, expected, actual);
		end
	endtask

	task automatic reportFailure(string what);
		errors++;
		$display("failure at %0t: %s", $time, what);
	endtask

	// Strobe and state rules on every falling edge
	always @(negedge Clk) begin
		if (!rst) begin
			if (memRead && memWrite)
				reportFailure("read and write strobes high together");
			if (u_dut.u_controlUnit.state == sHalted && (u_dut.cpuRead || u_dut.cpuWrite))
				reportFailure("memory strobe issued while halted");
			if (u_dut.cpuWrite && u_dut.u_controlUnit.state != sStWrite)
				reportFailure("write strobe outside the store write state");
			if ($isunknown(u_dut.u_controlUnit.state)
					|| u_dut.u_controlUnit.state > sPauseRelease)
				reportFailure("control state outside the legal set");
		end
	end

	// Reset for 4 cycles and refill memory and the logs
	task automatic beginTest();
		errAtStart = errors;
		@(posedge Clk);
		rst <= 1'b1;
		run <= 1'b0;
		cont <= 1'b0;
		repeat (4) @(posedge Clk);
		rst <= 1'b0;
		// Address dependent fill so stray reads show up
		for (int a = 0; a < 65536; a++)
			mem[a] = dataWord'(a) ^ 16'hA5C3;
		wrAddrQ.delete();
		wrDataQ.delete();
		readCount = 0;
		ioStrobes = 0;
	endtask

	task automatic finishTest(string name);
		testsRun++;
		if (errors == errAtStart) begin
			$display("test %s: ok", name);
		end else begin
			testsFailed++;
			$display("test %s: %0d errors", name, errors - errAtStart);
		end
	endtask

	task automatic pulseRun();
		@(posedge Clk);
		run <= 1'b1;
		@(posedge Clk);
		run <= 1'b0;
	endtask

	// Blocks until n external writes are logged
	task automatic waitWrites(int n);
		while (wrAddrQ.size() < n)
			@(negedge Clk);
	endtask

	task automatic checkWrite(int idx, dataWord addr, dataWord data);
		checkWord($sformatf("memAddr of write %0d", idx), addr, wrAddrQ[idx]);
		checkWord($sformatf("memWrData of write %0d", idx), data, wrDataQ[idx]);
	endtask

	task automatic resetAndHalt();
		beginTest();
		@(negedge Clk);
		checkWord("pc", 16'h0000, pc);
		checkWord("led", 16'h0000, {4'h0, led});
		// Display and PC digits all read zero
		for (int i = 0; i < 8; i++)
			checkSeg($sformatf("hex%0d", i), segTable[0], hex[i]);
		repeat (20) @(negedge Clk);
		if (readCount != 0 || wrAddrQ.size() != 0)
			reportFailure("memory strobe while halted with run low");
		checkWord("pc", 16'h0000, pc);
		finishTest("reset and halt");
	endtask

	task automatic aluOps();
		dataWord a;
		dataWord b;
		logic [4:0] immA;
		logic [4:0] immB;
		beginTest();
		a = dataWord'($urandom);
		b = dataWord'($urandom);
		immA = 5'($urandom);
		immB = 5'($urandom);
		mem[16'h40] = a;
		mem[16'h41] = b;
		mem[0] = memOp(opcLd, 3'd1, 16'd0, 16'h40);
		mem[1] = memOp(opcLd, 3'd2, 16'd1, 16'h41);
		mem[2] = aluReg(opcAdd, 3'd3, 3'd1, 3'd2);
		mem[3] = memOp(opcSt, 3'd3, 16'd3, 16'h50);
		mem[4] = aluReg(opcAnd, 3'd4, 3'd1, 3'd2);
		mem[5] = memOp(opcSt, 3'd4, 16'd5, 16'h51);
		// NOT R5, R1
		mem[6] = {4'b1001, 3'd5, 3'd1, 6'b111111};
		mem[7] = memOp(opcSt, 3'd5, 16'd7, 16'h52);
		mem[8] = aluImm(opcAdd, 3'd6, 3'd1, immA);
		mem[9] = memOp(opcSt, 3'd6, 16'd9, 16'h53);
		mem[10] = aluImm(opcAnd, 3'd7, 3'd2, immB);
		mem[11] = memOp(opcSt, 3'd7, 16'd11, 16'h54);
		mem[12] = branch(3'b111, 16'd12, 16'd12);
		pulseRun();
		waitWrites(5);
		checkWrite(0, 16'h50, a + b);
		checkWrite(1, 16'h51, a & b);
		checkWrite(2, 16'h52, ~a);
		checkWrite(3, 16'h53, a + {{11{immA[4]}}, immA});
		checkWrite(4, 16'h54, b & {{11{immB[4]}}, immB});
		finishTest("alu");
	endtask

	task automatic branchJump();
		dataWord count;
		int c;
		beginTest();
		count = dataWord'($urandom % 40) + 16'd1;
		// Counter steps down by 3 while positive
		c = count;
		do
			c -= 3;
		while (c > 0);
		mem[16'h40] = count;
		mem[16'h41] = 16'd6;
		mem[0] = memOp(opcLd, 3'd1, 16'd0, 16'h40);
		mem[1] = memOp(opcLd, 3'd2, 16'd1, 16'h41);
		mem[2] = aluImm(opcAdd, 3'd1, 3'd1, 5'b11101);
		mem[3] = branch(3'b001, 16'd3, 16'd2);
		// JMP R2 skips the store at 5
		mem[4] = {4'b1100, 3'b000, 3'd2, 6'b000000};
		mem[5] = memOp(opcSt, 3'd1, 16'd5, 16'h61);
		mem[6] = branch(3'b110, 16'd6, 16'd8);
		mem[7] = memOp(opcSt, 3'd1, 16'd7, 16'h61);
		mem[8] = memOp(opcSt, 3'd1, 16'd8, 16'h60);
		mem[9] = memOp(opcSt, 3'd2, 16'd9, 16'h62);
		mem[10] = branch(3'b111, 16'd10, 16'd10);
		pulseRun();
		waitWrites(2);
		checkWrite(0, 16'h60, dataWord'(c));
		checkWrite(1, 16'h62, 16'd6);
		finishTest("branch and jump");
	endtask

	task automatic ioAccess();
		dataWord shown;
		dataWord sw;
		beginTest();
		shown = dataWord'($urandom);
		sw = dataWord'($urandom);
		@(posedge Clk);
		switches <= sw;
		mem[16'h40] = shown;
		mem[0] = memOp(opcLd, 3'd1, 16'd0, 16'h40);
		mem[1] = memOp(opcSt, 3'd1, 16'd1, 16'hFFFF);
		mem[2] = memOp(opcLd, 3'd2, 16'd2, 16'hFFFF);
		mem[3] = memOp(opcSt, 3'd2, 16'd3, 16'h50);
		mem[4] = branch(3'b111, 16'd4, 16'd4);
		pulseRun();
		waitWrites(1);
		checkWrite(0, 16'h50, sw);
		for (int i = 0; i < 4; i++)
			checkSeg($sformatf("hex%0d", i), segTable[shown[4 * i +: 4]], hex[i]);
		if (ioStrobes != 0)
			reportFailure("I/O address reached the external memory strobes");
		finishTest("io");
	endtask

	task automatic pauseContinue();
		dataWord value;
		dataWord pausePc;
		logic [11:0] bits;
		int readsAtPause;
		beginTest();
		value = dataWord'($urandom);
		// Nonzero so the LED change is visible
		bits = 12'($urandom) | 12'h001;
		// PC points past the PAUSE at address 1
		pausePc = 16'd2;
		mem[16'h40] = value;
		mem[0] = memOp(opcLd, 3'd1, 16'd0, 16'h40);
		mem[1] = {4'b1101, bits};
		mem[2] = memOp(opcSt, 3'd1, 16'd2, 16'h50);
		mem[3] = branch(3'b111, 16'd3, 16'd3);
		pulseRun();
		while (led !== bits)
			@(negedge Clk);
		readsAtPause = readCount;
		repeat (20) @(negedge Clk);
		checkWord("pc", pausePc, pc);
		checkWord("ir", {4'b1101, bits}, ir);
		checkWord("led", {4'h0, bits}, {4'h0, led});
		// High digits hold the paused PC
		for (int i = 0; i < 4; i++)
			checkSeg($sformatf("hex%0d", i + 4), segTable[pausePc[4 * i +: 4]], hex[i + 4]);
		if (readCount != readsAtPause || wrAddrQ.size() != 0)
			reportFailure("memory strobe while paused");
		@(posedge Clk);
		cont <= 1'b1;
		repeat (3) @(posedge Clk);
		cont <= 1'b0;
		waitWrites(1);
		checkWrite(0, 16'h50, value);
		finishTest("pause");
	endtask

	// Run limit from the test count and program length
	initial begin
		cycles = 0;
		while (cycles < cycleLimit) begin
			@(posedge Clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		void'($urandom(32'hcafd_d429));
		rst <= 1'b1;
		run <= 1'b0;
		cont <= 1'b0;
		switches <= '0;
		memRdData <= '0;
		errors = 0;
		testsRun = 0;
		testsFailed = 0;
		readCount = 0;
		ioStrobes = 0;
		resetAndHalt();
		aluOps();
		branchJump();
		ioAccess();
		pauseContinue();
		$display("%0d tests run, %0d failing, %0d errors", testsRun, testsFailed, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

/* compile.f */
source/slc3Pkg.sv
source/hexDriver.sv
source/regFile.sv
source/datapath.sv
source/controlUnit.sv
source/memIo.sv
source/slc3.sv
bench/controlUnit_properties.sv
bench/slc3Tb.sv
